// File: compile.f
+incdir+.
cfg_cdc_pkg.sv
handshake_sync.sv
axis_config_reg_cdc.sv
cfg_cmd_decode.sv
cfg_reg_execute.sv
cfg_resp_result.sv
cfg_subsystem_top.sv
tb_cfg_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# build and run the config subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_cfg_subsystem \
  -o vsim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/vsim_tb > sim.log 2>&1
status=$?
cat sim.log
[ "$status" -eq 0 ] && ! grep -q "TESTS FAILED" sim.log \
  && echo "simulation finished without failures" \
  || { echo "simulation reported a failure"; exit 1; }

// File: tb_cfg_subsystem.sv
// testbench for the config register subsystem, two unrelated clocks
// applies a command table through the crossing and checks every tagged response
`include "cfg_cdc_settings.svh"
`default_nettype none

module tb_cfg_subsystem import cfg_cdc_pkg::*;;

localparam int TIMEOUT_CYCLES = 200;
localparam int HOLD_CYCLES    = 90;   // long enough for the whole path to back up
localparam int VW             = `CFG_VALUE_W;

logic                                 src_clk    = 1'b0;
logic                                 dest_clk   = 1'b0;
logic                                 src_reset  = 1'b1;
logic                                 dest_reset = 1'b1;
logic                                 src_valid  = 1'b0;
logic [`CFG_DWIDTH-1:0]               src_data   = '0;
logic                                 resp_ready = 1'b0;
wire                                  src_ready;
wire                                  resp_valid;
wire  [`CFG_RESP_W-1:0]               resp_data;
wire  [`CFG_NUM_REGS*`CFG_VALUE_W-1:0] reg_values;

always #10 dest_clk = ~dest_clk;
always #7  src_clk  = ~src_clk;   // 14 period, unrelated to dest_clk

cfg_subsystem_top u_cfg_subsystem_top (
  .src_clk, .src_reset, .src_valid, .src_ready, .src_data,
  .dest_clk, .dest_reset, .resp_valid, .resp_ready, .resp_data, .reg_values
);

////////////////////////////////////////////////////////////
// command table, stall 0 none, 1 random ready, 2 hold ready low
////////////////////////////////////////////////////////////
string                   names_q[$];
cfg_op_e                 ops_q[$];
logic [`CFG_ADDR_W-1:0]  addrs_q[$];
logic [`CFG_VALUE_W-1:0] values_q[$];
int                      stalls_q[$];

logic [`CFG_VALUE_W-1:0] model_regs [`CFG_NUM_REGS]; // expected bank
logic [`CFG_TAG_W-1:0]   model_tag;
int                      sent;      // commands accepted on the source stream
int                      errors;
int                      prior_errors; // error count when a single check starts
int                      tests;
bit                      aborted;   // set on any timeout

task automatic add_cmd(input string name, input cfg_op_e op,
                       input logic [`CFG_ADDR_W-1:0] addr,
                       input logic [`CFG_VALUE_W-1:0] value, input int stall);
  names_q.push_back(name);
  ops_q.push_back(op);
  addrs_q.push_back(addr);
  values_q.push_back(value);
  stalls_q.push_back(stall);
endtask

// opcode rule of the register bank
function automatic logic [`CFG_VALUE_W-1:0] apply_op(input cfg_op_e op,
    input logic [`CFG_VALUE_W-1:0] cur, input logic [`CFG_VALUE_W-1:0] val);
  case (op)
    CFG_WRITE: return val;
    CFG_SET:   return cur | val;
    CFG_CLEAR: return cur & ~val;
    default:   return cur;      // read
  endcase
endfunction

////////////////////////////////////////////////////////////
// source side driver
////////////////////////////////////////////////////////////
task automatic drive_commands();
  int waited;
  @(posedge src_clk);
  #1;
  for (int i = 0; i < names_q.size() && !aborted; i++) begin
    waited    = 0;
    src_valid = 1'b1;
    src_data  = {ops_q[i], addrs_q[i], values_q[i]};
    @(posedge src_clk);
    while (!src_ready && waited < TIMEOUT_CYCLES) begin // pre-edge ready
      @(posedge src_clk);
      waited++;
    end
    if (!src_ready) begin
      $display("timeout waiting for src_ready to send %s", names_q[i]);
      errors++;
      aborted = 1'b1;
    end else begin
      sent++;
    end
    #1;
    src_valid = 1'b0;
  end
endtask

////////////////////////////////////////////////////////////
// response checker
////////////////////////////////////////////////////////////
task automatic check_responses();
  int                                   waited;
  int                                   idx;
  bit                                   test_ok;
  logic [31:0]                          rnd;
  logic [`CFG_RESP_W-1:0]               got;
  logic [`CFG_RESP_W-1:0]               exp_resp;
  logic [`CFG_VALUE_W-1:0]              exp_value;
  logic [`CFG_NUM_REGS*`CFG_VALUE_W-1:0] regs;
  for (int i = 0; i < names_q.size() && !aborted; i++) begin
    test_ok = 1'b1;
    waited  = 0;
    if (stalls_q[i] == 2) begin
      resp_ready = 1'b0;
      repeat (HOLD_CYCLES) @(posedge dest_clk);
      if (src_ready !== 1'b0) begin
        $display("src_ready stayed high while responses were held back in %s", names_q[i]);
        errors++;
        test_ok = 1'b0;
      end
      // one word each in result, execute and decode, one more stuck in the crossing
      if (sent != i + 4) begin
        $display("Error %s accepted commands expected %0d actual %0d", names_q[i],
                 i + 4, sent);
        errors++;
        test_ok = 1'b0;
      end
      #1;
    end
    rnd        = $urandom;
    resp_ready = (stalls_q[i] == 1) ? rnd[0] : 1'b1;
    @(posedge dest_clk);
    while (!(resp_valid && resp_ready) && waited < TIMEOUT_CYCLES) begin
      #1;
      if (stalls_q[i] == 1) begin
        rnd        = $urandom;
        resp_ready = rnd[0];
      end
      @(posedge dest_clk);
      waited++;
    end
    if (!(resp_valid && resp_ready)) begin
      $display("timeout waiting for the response to %s", names_q[i]);
      errors++;
      aborted = 1'b1;
    end else begin
      got  = resp_data;    // values from before this edge
      regs = reg_values;
      idx  = addrs_q[i];
      exp_value = apply_op(ops_q[i], model_regs[idx], values_q[i]);
      model_regs[idx] = exp_value;
      exp_resp  = {model_tag, addrs_q[i], exp_value};
      model_tag++;
      if (got !== exp_resp) begin
        $display("Error %s response expected %h actual %h", names_q[i], exp_resp, got);
        errors++;
        test_ok = 1'b0;
      end
      // the bank slice is only settled when nothing later has been accepted yet
      if (sent == i + 1 && regs[idx*VW +: VW] !== exp_value) begin
        $display("Error %s reg %0d expected %h actual %h", names_q[i], idx,
                 exp_value, regs[idx*VW +: VW]);
        errors++;
        test_ok = 1'b0;
      end
    end
    tests++;
    $display("%-18s %s", names_q[i], test_ok ? "ok" : "failed");
    #1;
    resp_ready = 1'b0;
  end
endtask

////////////////////////////////////////////////////////////
// main sequence
////////////////////////////////////////////////////////////
initial begin
  sent      = 0;
  errors    = 0;
  tests     = 0;
  aborted   = 1'b0;
  model_tag = '0;
  for (int r = 0; r < `CFG_NUM_REGS; r++) model_regs[r] = '0;
  void'($urandom(32'ha1d5d215));

  add_cmd("write_a0",        CFG_WRITE, 4'd0,  10'h155, 0);
  add_cmd("write_a5",        CFG_WRITE, 4'd5,  10'h2aa, 0);
  add_cmd("write_a15",       CFG_WRITE, 4'd15, 10'h3ff, 0);
  add_cmd("write_a9",        CFG_WRITE, 4'd9,  10'h0f0, 0);
  add_cmd("set_a0",          CFG_SET,   4'd0,  10'h20a, 0);
  add_cmd("clear_a15",       CFG_CLEAR, 4'd15, 10'h0ff, 0);
  add_cmd("read_a5",         CFG_READ,  4'd5,  10'h123, 0); // value field ignored
  add_cmd("set_a9",          CFG_SET,   4'd9,  10'h00f, 1);
  add_cmd("clear_a0",        CFG_CLEAR, 4'd0,  10'h001, 1);
  add_cmd("read_a9",         CFG_READ,  4'd9,  10'h000, 1);
  add_cmd("write_a3",        CFG_WRITE, 4'd3,  10'h3c3, 1);
  add_cmd("hold_write_a7",   CFG_WRITE, 4'd7,  10'h07e, 2); // next four back up
  add_cmd("burst_set_a7",    CFG_SET,   4'd7,  10'h300, 0);
  add_cmd("burst_clear_a3",  CFG_CLEAR, 4'd3,  10'h0c3, 0);
  add_cmd("burst_write_a12", CFG_WRITE, 4'd12, 10'h1b6, 0);
  add_cmd("burst_read_a7",   CFG_READ,  4'd7,  10'h000, 0);
  add_cmd("wrap_write_a1",   CFG_WRITE, 4'd1,  10'h011, 0); // tag back to 0
  add_cmd("wrap_set_a1",     CFG_SET,   4'd1,  10'h100, 1);
  add_cmd("wrap_read_a0",    CFG_READ,  4'd0,  10'h000, 1);
  add_cmd("hold_write_a14",  CFG_WRITE, 4'd14, 10'h2d2, 2);
  add_cmd("clear_a14",       CFG_CLEAR, 4'd14, 10'h0f0, 0);
  add_cmd("set_a12",         CFG_SET,   4'd12, 10'h001, 0);
  add_cmd("read_a15",        CFG_READ,  4'd15, 10'h000, 0);
  add_cmd("write_a6",        CFG_WRITE, 4'd6,  10'h0aa, 0);
  add_cmd("read_a6",         CFG_READ,  4'd6,  10'h000, 1);

  fork
    begin
      repeat (10) @(posedge dest_clk);
      #1 dest_reset = 1'b0;
    end
    begin
      repeat (10) @(posedge src_clk);
      #1 src_reset = 1'b0;
    end
  join
  repeat (3) @(posedge dest_clk);
  #1;

  // state straight out of reset
  tests++;
  prior_errors = errors;
  if (src_ready !== 1'b1 || resp_valid !== 1'b0 || reg_values !== '0) begin
    $display("Error after_reset expected ready 1 valid 0 regs 0 actual ready %b valid %b regs %h",
             src_ready, resp_valid, reg_values);
    errors++;
  end
  $display("%-18s %s", "after_reset", (errors == prior_errors) ? "ok" : "failed");

  fork
    drive_commands();
    check_responses();
  join

  // no extra response, and the bank matches the model
  if (!aborted) begin
    tests++;
    prior_errors = errors;
    #1 resp_ready = 1'b1;
    repeat (20) begin
      @(posedge dest_clk);
      if (resp_valid) begin
        $display("an extra response appeared after the last command");
        errors++;
      end
    end
    for (int r = 0; r < `CFG_NUM_REGS; r++) begin
      if (reg_values[r*VW +: VW] !== model_regs[r]) begin
        $display("Error final_bank reg %0d expected %h actual %h", r, model_regs[r],
                 reg_values[r*VW +: VW]);
        errors++;
      end
    end
    $display("%-18s %s", "final_bank", (errors == prior_errors) ? "ok" : "failed");
  end

  $display("%0d tests run, %0d errors", tests, errors);
  if (errors == 0 && !aborted) begin
    $display("TESTS PASSED");
  end else begin
    $display("TESTS FAILED");
  end
  $finish;
end

endmodule

`default_nettype wire

// File: cfg_subsystem_top.sv
// config register subsystem top, src_clk command stream in
// dest_clk tagged responses and the flat register bank out
`include "cfg_cdc_settings.svh"
`default_nettype none

module cfg_subsystem_top import cfg_cdc_pkg::*; (
  input  wire                     src_clk,
  input  wire                     src_reset,
  input  wire                     src_valid,
  output wire                     src_ready,
  input  wire  [`CFG_DWIDTH-1:0]  src_data,

  input  wire                     dest_clk,
  input  wire                     dest_reset,
  output wire                     resp_valid,
  input  wire                     resp_ready,
  output wire  [`CFG_RESP_W-1:0]  resp_data,
  output wire  [`CFG_NUM_REGS*`CFG_VALUE_W-1:0] reg_values
);

////////////////////////////////////////////////////////////
// stage streams, all dest_clk
////////////////////////////////////////////////////////////
wire                     cfg_valid;
wire                     cfg_ready;
wire [`CFG_DWIDTH-1:0]   cfg_data;
wire                     dec_valid;
wire                     dec_ready;
wire cfg_op_e            dec_op;
wire [`CFG_ADDR_W-1:0]   dec_addr;
wire [`CFG_VALUE_W-1:0]  dec_value;
wire                     exe_valid;
wire                     exe_ready;
wire [`CFG_ADDR_W-1:0]   exe_addr;
wire [`CFG_VALUE_W-1:0]  exe_value;

axis_config_reg_cdc #(
  .DWIDTH(`CFG_DWIDTH)
) u_cdc (
  .src_clk, .src_reset, .src_valid, .src_ready, .src_data,
  .dest_clk, .dest_reset, .cfg_valid, .cfg_ready, .cfg_data
);

cfg_cmd_decode u_decode (
  .dest_clk, .dest_reset, .cfg_valid, .cfg_ready, .cfg_data,
  .dec_valid, .dec_ready, .dec_op, .dec_addr, .dec_value
);

cfg_reg_execute u_execute (
  .dest_clk, .dest_reset, .dec_valid, .dec_ready, .dec_op, .dec_addr, .dec_value,
  .exe_valid, .exe_ready, .exe_addr, .exe_value, .reg_values
);

cfg_resp_result u_result (
  .dest_clk, .dest_reset, .exe_valid, .exe_ready, .exe_addr, .exe_value,
  .resp_valid, .resp_ready, .resp_data
);

endmodule

`default_nettype wire

// File: cfg_resp_result.sv
// result stage, tags each executed op and drives the response stream
// holds the response while the consumer stalls
`include "cfg_cdc_settings.svh"
`default_nettype none

module cfg_resp_result (
  input  wire                     dest_clk,
  input  wire                     dest_reset,

  input  wire                     exe_valid,
  output logic                    exe_ready,
  input  wire  [`CFG_ADDR_W-1:0]  exe_addr,
  input  wire  [`CFG_VALUE_W-1:0] exe_value,

  output logic                    resp_valid,
  input  wire                     resp_ready,
  output logic [`CFG_RESP_W-1:0]  resp_data   // {tag, addr, value}
);

logic [`CFG_TAG_W-1:0] tag;       // sequence number of the next response
logic                  exe_take;

assign exe_ready = ~resp_valid | resp_ready;
assign exe_take  = exe_valid & exe_ready;

always_ff @(posedge dest_clk) begin
  if (dest_reset) begin
    resp_valid <= 1'b0;
    tag        <= '0;
  end else if (exe_take) begin
    resp_valid <= 1'b1;
    tag        <= tag + 1'b1;   // wraps at 16
  end else if (resp_ready) begin
    resp_valid <= 1'b0;
  end
end

always_ff @(posedge dest_clk) begin
  if (exe_take) resp_data <= {tag, exe_addr, exe_value};
end

// a response stays up until the consumer takes it
assert property (@(posedge dest_clk) disable iff (dest_reset)
  resp_valid && !resp_ready |=> resp_valid)
  else $error("cfg_resp_result: resp_valid dropped without a handshake");

endmodule

`default_nettype wire

// File: cfg_reg_execute.sv
// execute stage, holds the sixteen config registers and applies each opcode
// forwards the address and resulting value toward the result stage
`include "cfg_cdc_settings.svh"
`default_nettype none

module cfg_reg_execute import cfg_cdc_pkg::*; (
  input  wire                     dest_clk,
  input  wire                     dest_reset,

  input  wire                     dec_valid,
  output logic                    dec_ready,
  input  wire cfg_op_e            dec_op,
  input  wire  [`CFG_ADDR_W-1:0]  dec_addr,
  input  wire  [`CFG_VALUE_W-1:0] dec_value,

  output logic                    exe_valid,
  input  wire                     exe_ready,
  output logic [`CFG_ADDR_W-1:0]  exe_addr,
  output logic [`CFG_VALUE_W-1:0] exe_value,

  output logic [`CFG_NUM_REGS*`CFG_VALUE_W-1:0] reg_values // reg 0 in low bits
);

logic [`CFG_VALUE_W-1:0] bank [`CFG_NUM_REGS];
logic [`CFG_VALUE_W-1:0] cur_value;   // addressed register before the op
logic [`CFG_VALUE_W-1:0] new_value;   // and after it
logic                    dec_take;

assign dec_ready = ~exe_valid | exe_ready;
assign dec_take  = dec_valid & dec_ready;
assign cur_value = bank[dec_addr];

////////////////////////////////////////////////////////////
// opcode rule
////////////////////////////////////////////////////////////
always_comb begin
  case (dec_op)
    CFG_WRITE: new_value = dec_value;
    CFG_SET:   new_value = cur_value | dec_value;
    CFG_CLEAR: new_value = cur_value & ~dec_value;
    default:   new_value = cur_value; // read leaves it as is
  endcase
end

////////////////////////////////////////////////////////////
// register bank and output register
////////////////////////////////////////////////////////////
always_ff @(posedge dest_clk) begin
  if (dest_reset) begin
    for (int i = 0; i < `CFG_NUM_REGS; i++) begin
      bank[i] <= '0;
    end
    exe_valid <= 1'b0;
  end else if (dec_take) begin
    bank[dec_addr] <= new_value;   // same edge as exe_valid below
    exe_valid      <= 1'b1;
  end else if (exe_ready) begin
    exe_valid <= 1'b0;
  end
end

always_ff @(posedge dest_clk) begin
  if (dec_take) begin
    exe_addr  <= dec_addr;
    exe_value <= new_value;
  end
end

// flat view of the bank
always_comb begin
  for (int i = 0; i < `CFG_NUM_REGS; i++) begin
    reg_values[i*`CFG_VALUE_W +: `CFG_VALUE_W] = bank[i];
  end
end

// decode always hands over a known opcode
assert property (@(posedge dest_clk) disable iff (dest_reset)
  dec_valid |-> !$isunknown(dec_op))
  else $error("cfg_reg_execute: unknown opcode with dec_valid high");

endmodule

`default_nettype wire

// File: cfg_cmd_decode.sv
// decode stage, splits a command word into opcode, address and value
// one-entry pipeline register between the crossing and execute
`include "cfg_cdc_settings.svh"
`default_nettype none

module cfg_cmd_decode import cfg_cdc_pkg::*; (
  input  wire                     dest_clk,
  input  wire                     dest_reset,

  input  wire                     cfg_valid,
  output logic                    cfg_ready,
  input  wire  [`CFG_DWIDTH-1:0]  cfg_data,

  output logic                    dec_valid,
  input  wire                     dec_ready,
  output cfg_op_e                 dec_op,
  output logic [`CFG_ADDR_W-1:0]  dec_addr,
  output logic [`CFG_VALUE_W-1:0] dec_value
);

// field positions inside the word
localparam int ADDR_LSB = `CFG_VALUE_W;               // 10
localparam int OP_LSB   = `CFG_VALUE_W + `CFG_ADDR_W; // 14

logic cfg_take;

// room when empty or when execute drains us this cycle
assign cfg_ready = ~dec_valid | dec_ready;
assign cfg_take  = cfg_valid & cfg_ready;

////////////////////////////////////////////////////////////
// pipeline register
////////////////////////////////////////////////////////////
always_ff @(posedge dest_clk) begin
  if (dest_reset) begin
    dec_valid <= 1'b0;
  end else if (cfg_take) begin
    dec_valid <= 1'b1;
  end else if (dec_ready) begin
    dec_valid <= 1'b0;     // entry went to execute
  end
end

// fields only load on a handshake, held otherwise
always_ff @(posedge dest_clk) begin
  if (cfg_take) begin
    dec_op    <= cfg_op_e'(cfg_data[OP_LSB +: `CFG_OP_W]);
    dec_addr  <= cfg_data[ADDR_LSB +: `CFG_ADDR_W];
    dec_value <= cfg_data[`CFG_VALUE_W-1:0];
  end
end

endmodule

`default_nettype wire

// File: axis_config_reg_cdc.sv
// moves config words from a src_clk stream to a dest_clk stream
// one word in flight at a time, back-pressure honoured on both sides
`include "cfg_cdc_settings.svh"
`default_nettype none

module axis_config_reg_cdc #(
  parameter int DWIDTH = `CFG_DWIDTH
) (
  input  wire               src_clk,
  input  wire               src_reset,
  input  wire               src_valid,
  output logic              src_ready,
  input  wire  [DWIDTH-1:0] src_data,

  input  wire               dest_clk,
  input  wire               dest_reset,
  output logic              cfg_valid,
  input  wire               cfg_ready,
  output logic [DWIDTH-1:0] cfg_data
);

////////////////////////////////////////////////////////////
// source side back-pressure
////////////////////////////////////////////////////////////
logic              src_send;
logic              src_rcv;
logic              src_take;   // handshake on the source stream
logic [DWIDTH-1:0] src_word;

// no new word until the last ack has risen and fallen
assign src_ready = ~(src_send | src_rcv);
assign src_take  = src_valid & src_ready;

always_ff @(posedge src_clk) begin
  if (src_take) src_word <= src_data;
end

always_ff @(posedge src_clk) begin
  if (src_reset) begin
    src_send <= 1'b0;
  end else if (src_take) begin
    src_send <= 1'b1;
  end else if (src_send && src_rcv) begin
    src_send <= 1'b0;          // ack is back, let the request drop
  end
end

////////////////////////////////////////////////////////////
// destination side back-pressure
////////////////////////////////////////////////////////////
logic              dest_req;
logic              dest_ack;
logic [DWIDTH-1:0] dest_word;
logic              transfer_done; // word already passed on for this req

always_ff @(posedge dest_clk) begin
  if (dest_reset) begin
    cfg_valid     <= 1'b0;
    dest_ack      <= 1'b0;
    transfer_done <= 1'b0;
  end else begin
    if (cfg_valid) begin
      if (cfg_ready) begin
        cfg_valid     <= 1'b0;   // taken by decode
        transfer_done <= 1'b1;
        dest_ack      <= 1'b1;
      end
    end else if (dest_req && !transfer_done) begin
      cfg_valid <= 1'b1;         // present the word once
    end else if (dest_ack && !dest_req) begin
      // request gone, ready for the next one
      dest_ack      <= 1'b0;
      transfer_done <= 1'b0;
    end
  end
end

always_ff @(posedge dest_clk) begin
  if (!cfg_valid && dest_req && !transfer_done) cfg_data <= dest_word;
end

////////////////////////////////////////////////////////////
// synchronizer
////////////////////////////////////////////////////////////
handshake_sync #(
  .DWIDTH(DWIDTH)
) u_sync (
  .src_clk,
  .src_reset,
  .src_send,
  .src_in   (src_word),
  .src_rcv,
  .dest_clk,
  .dest_reset,
  .dest_req,
  .dest_out (dest_word),
  .dest_ack
);

// a stalled word must not change under decode
assert property (@(posedge dest_clk) disable iff (dest_reset)
  cfg_valid && !cfg_ready |=> cfg_valid && $stable(cfg_data))
  else $error("axis_config_reg_cdc: cfg word changed while stalled");

endmodule

`default_nettype wire

// File: handshake_sync.sv
// behavioral four-phase request/ack crossing of one data word
// request goes src->dest and ack goes dest->src through `CFG_SYNC_STAGES flops each
`include "cfg_cdc_settings.svh"
`default_nettype none

module handshake_sync import cfg_cdc_pkg::*; #(
  parameter int DWIDTH = `CFG_DWIDTH
) (
  input  wire               src_clk,
  input  wire               src_reset,
  input  wire               src_send,   // keep high until src_rcv
  input  wire  [DWIDTH-1:0] src_in,
  output logic              src_rcv,    // ack seen in src domain

  input  wire               dest_clk,
  input  wire               dest_reset,
  output logic              dest_req,   // request seen in dest domain
  output logic [DWIDTH-1:0] dest_out,
  input  wire               dest_ack
);

localparam int STAGES = `CFG_SYNC_STAGES;

////////////////////////////////////////////////////////////
// source clock domain
////////////////////////////////////////////////////////////
hsk_state_e        src_state;
logic              src_req;    // request level launched toward dest
logic [DWIDTH-1:0] src_hold;   // word kept still for the whole crossing
logic [STAGES-1:0] ack_sync;   // dest_ack brought into src_clk

always_ff @(posedge src_clk) begin
  if (src_reset) begin
    src_state <= HSK_IDLE;
    src_req   <= 1'b0;
  end else begin
    case (src_state)
      HSK_IDLE: begin
        if (src_send) begin
          src_req   <= 1'b1;
          src_state <= HSK_REQ;
        end
      end
      HSK_REQ: begin
        // sender drops send only after rcv, so req follows
        if (!src_send) begin
          src_req   <= 1'b0;
          src_state <= HSK_WAIT_ACK_LOW;
        end
      end
      HSK_WAIT_ACK_LOW: begin
        if (!src_rcv) src_state <= HSK_IDLE; // ack fell, next word may start
      end
      default: src_state <= HSK_IDLE;
    endcase
  end
end

// capture once, as the request starts
always_ff @(posedge src_clk) begin
  if (src_state == HSK_IDLE && src_send) src_hold <= src_in;
end

always_ff @(posedge src_clk) begin
  if (src_reset) ack_sync <= '0;
  else           ack_sync <= {ack_sync[STAGES-2:0], dest_ack};
end

assign src_rcv = ack_sync[STAGES-1];

////////////////////////////////////////////////////////////
// destination clock domain
////////////////////////////////////////////////////////////
logic [STAGES-1:0] req_sync; // src_req brought into dest_clk

always_ff @(posedge dest_clk) begin
  if (dest_reset) req_sync <= '0;
  else            req_sync <= {req_sync[STAGES-2:0], src_req};
end

assign dest_req = req_sync[STAGES-1];

// src_hold has been still for several cycles by the time req gets here
always_ff @(posedge dest_clk) begin
  if (req_sync[STAGES-2] && !req_sync[STAGES-1]) dest_out <= src_hold;
end

// send must stay up until the ack has made it back
assert property (@(posedge src_clk) disable iff (src_reset)
  $fell(src_send) |-> src_rcv)
  else $error("handshake_sync: src_send fell before src_rcv rose");

endmodule

`default_nettype wire

// File: cfg_cdc_pkg.sv
// enum types shared by the config crossing and its dest-side stages
// compile ahead of every module that imports it
`include "cfg_cdc_settings.svh"
`default_nettype none

package cfg_cdc_pkg;

  ////////////////////////////////////////////////////////////
  // command opcodes
  ////////////////////////////////////////////////////////////
  // taken from the top bits of a command word
  typedef enum logic [`CFG_OP_W-1:0] {
    CFG_WRITE = 2'd0, // replace the register
    CFG_SET   = 2'd1, // or the value bits in
    CFG_CLEAR = 2'd2, // clear the bits set in the value
    CFG_READ  = 2'd3  // leave the register, report it
  } cfg_op_e;

  ////////////////////////////////////////////////////////////
  // synchronizer source side
  ////////////////////////////////////////////////////////////
  // four-phase sequence as seen from src_clk
  typedef enum logic [1:0] {
    HSK_IDLE         = 2'd0, // free, waiting for a send
    HSK_REQ          = 2'd1, // request level held high
    HSK_WAIT_ACK_LOW = 2'd2  // request dropped, ack still on its way down
  } hsk_state_e;

endpackage

`default_nettype wire

// File: cfg_cdc_settings.svh
// width, count and depth macros for the config register crossing
// include in any file that sizes a port or a register from them
`ifndef CFG_CDC_SETTINGS_SVH
`define CFG_CDC_SETTINGS_SVH

////////////////////////////////////////////////////////////
// command word layout
////////////////////////////////////////////////////////////
`define CFG_DWIDTH      16 // whole command word
`define CFG_OP_W        2  // opcode in bits 15..14
`define CFG_ADDR_W      4  // register address in bits 13..10
`define CFG_VALUE_W     10 // register value in bits 9..0

////////////////////////////////////////////////////////////
// register bank and crossing
////////////////////////////////////////////////////////////
`define CFG_NUM_REGS    16 // one register per address
`define CFG_SYNC_STAGES 4  // flops per direction in the synchronizer

////////////////////////////////////////////////////////////
// response word holds tag then address then value
////////////////////////////////////////////////////////////
`define CFG_TAG_W       4  // wraps after 15
`define CFG_RESP_W      18

`endif
